// File: src/noise_pkg.sv
package noise_pkg;

    ////////////////////
    // Register map
    ////////////////////

    localparam logic [1:0] ADDR_LENGTH   = 2'd0; // Length in bits 5:0
    localparam logic [1:0] ADDR_ENVELOPE = 2'd1; // Vol 7:4, dir 3, sweeps 2:0
    localparam logic [1:0] ADDR_POLY     = 2'd2; // Prescale 7:4, width 3, ratio 2:0
    localparam logic [1:0] ADDR_CONTROL  = 2'd3; // Trigger 7, single 6

    ////////////////////
    // Field widths
    ////////////////////

    localparam integer VOL_W        = 4;  // Volume and level
    localparam integer LEN_W        = 6;  // Length field
    localparam integer LFSR_W       = 15; // Long noise register
    localparam integer LFSR_SHORT_W = 7;  // Short (metallic) mode

    ////////////////////
    // Timing
    ////////////////////

    // clk cycles per frame step, kept small for simulation
    localparam logic [15:0] FRAME_STEP_CLKS = 16'd64;

    localparam integer NOISE_BASE_DIV   = 8;  // Divisor for ratio 0
    localparam integer NOISE_RATIO_MULT = 16; // Divisor per ratio unit
    localparam integer SHIFT_STOP       = 14; // Prescale at or above: LFSR frozen

    ////////////////////
    // Frame-step decode
    ////////////////////

    // Length clock on even steps
    localparam logic [7:0] LENGTH_STEPS = 8'b0101_0101;

    // Envelope clock on the last step
    localparam logic [2:0] ENV_STEP = 3'd7;

endpackage

// File: src/noise_reg_decode.sv
`timescale 1ns/1ps

module noise_reg_decode (
    input  logic                           clk,
    input  logic                           start,
    input  logic                           wr_en,
    input  logic [1:0]                     wr_addr,
    input  logic [7:0]                     wr_data,
    output logic [noise_pkg::LEN_W-1:0]    length,
    output logic [noise_pkg::VOL_W-1:0]    initial_volume,
    output logic                           env_increasing,
    output logic [2:0]                     env_sweeps,
    output logic [3:0]                     shift_prescale,
    output logic                           short_mode,
    output logic [2:0]                     div_ratio,
    output logic                           single,
    output logic                           trigger,
    output logic                           dac_on
);

    logic ctrl_trig_wr; // Control write with trigger bit set

    assign ctrl_trig_wr = wr_en && (wr_addr == noise_pkg::ADDR_CONTROL) && wr_data[7];

    // Field capture, one register per address
    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            length         <= '0;
            initial_volume <= '0;
            env_increasing <= 1'b0;
            env_sweeps     <= '0;
            shift_prescale <= '0;
            short_mode     <= 1'b0;
            div_ratio      <= '0;
            single         <= 1'b0;
        end else if (wr_en) begin
            case (wr_addr)
                noise_pkg::ADDR_LENGTH: length <= wr_data[noise_pkg::LEN_W-1:0];
                noise_pkg::ADDR_ENVELOPE: begin
                    initial_volume <= wr_data[7:4];
                    env_increasing <= wr_data[3]; // 1 = rising
                    env_sweeps     <= wr_data[2:0];
                end
                noise_pkg::ADDR_POLY: begin
                    shift_prescale <= wr_data[7:4];
                    short_mode     <= wr_data[3]; // 1 = 7-bit LFSR
                    div_ratio      <= wr_data[2:0];
                end
                default: single <= wr_data[6]; // Control register
            endcase
        end
    end

    // Trigger pulse, one cycle after the write
    // A second trigger write during the pulse merges into it
    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            trigger <= 1'b0;
        end else begin
            trigger <= ctrl_trig_wr && !trigger;
        end
    end

    // DAC powered unless envelope is silent and falling
    assign dac_on = (initial_volume != '0) || env_increasing;

    a_trigger_single: assert property (
        @(posedge clk) disable iff (start) trigger |=> !trigger
    );

endmodule

// File: src/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic clk,
    input  logic start,
    output logic length_tick,
    output logic env_tick
);

    logic [15:0] prescale_cnt; // clk cycles within the step
    logic [2:0]  step;         // Current frame step, wraps at 8
    logic        step_end;

    assign step_end = (prescale_cnt == noise_pkg::FRAME_STEP_CLKS - 16'd1);

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            prescale_cnt <= '0;
            step         <= '0;
            length_tick  <= 1'b0;
            env_tick     <= 1'b0;
        end else begin
            prescale_cnt <= step_end ? 16'd0 : prescale_cnt + 16'd1;
            // Ticks decoded from the step just finished
            length_tick  <= step_end && noise_pkg::LENGTH_STEPS[step];
            env_tick     <= step_end && (step == noise_pkg::ENV_STEP);
            if (step_end)
                step <= step + 3'd1; // Free running, no restart
        end
    end

    a_ticks_exclusive: assert property (
        @(posedge clk) disable iff (start) !(length_tick && env_tick)
    );

endmodule

// File: src/noise_lfsr_gen.sv
`timescale 1ns/1ps

module noise_lfsr_gen (
    input  logic       clk,
    input  logic       start,
    input  logic       trigger,
    input  logic [3:0] shift_prescale,
    input  logic       short_mode,
    input  logic [2:0] div_ratio,
    output logic       noise_bit
);

    logic [6:0]                    divisor;  // Up to 7 * 16
    logic [21:0]                   period;   // divisor << prescale, worst case 22 bits
    logic [21:0]                   timer;    // Cycles left to next step
    logic                          expire;
    logic                          frozen;
    logic                          feedback;
    logic [noise_pkg::LFSR_W-1:0]  lfsr;
    logic [noise_pkg::LFSR_W-1:0]  lfsr_next;

    ////////////////////
    // Step period
    ////////////////////

    assign divisor = (div_ratio == 3'd0) ? 7'(noise_pkg::NOISE_BASE_DIV) :
                     7'(div_ratio * noise_pkg::NOISE_RATIO_MULT);
    assign period  = {15'd0, divisor} << shift_prescale;
    assign expire  = (timer == '0);
    assign frozen  = (shift_prescale >= 4'(noise_pkg::SHIFT_STOP)); // Clock stopped

    ////////////////////
    // Shift register
    ////////////////////

    assign feedback = lfsr[0] ^ lfsr[1];

    always_comb begin
        if (short_mode) // Feedback at bit 6, upper bits dropped
            lfsr_next = {{(noise_pkg::LFSR_W - noise_pkg::LFSR_SHORT_W){1'b0}},
                         feedback, lfsr[noise_pkg::LFSR_SHORT_W-1:1]};
        else
            lfsr_next = {feedback, lfsr[noise_pkg::LFSR_W-1:1]};
    end

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            timer <= '0;
            lfsr  <= '1;
        end else if (trigger) begin
            timer <= period - 22'd1; // First step one full period out
            lfsr  <= '1;
        end else if (expire) begin
            timer <= period - 22'd1;
            if (!frozen)
                lfsr <= lfsr_next;
        end else begin
            timer <= timer - 22'd1;
        end
    end

    assign noise_bit = ~lfsr[0]; // High output on a 0 bit

    a_lfsr_nonzero: assert property (
        @(posedge clk) disable iff (start) lfsr != '0
    );

endmodule

// File: src/volume_envelope.sv
`timescale 1ns/1ps

module volume_envelope (
    input  logic                        clk,
    input  logic                        start,
    input  logic                        trigger,
    input  logic                        env_tick,
    input  logic [noise_pkg::VOL_W-1:0] initial_volume,
    input  logic                        env_increasing,
    input  logic [2:0]                  env_sweeps,
    output logic [noise_pkg::VOL_W-1:0] volume
);

    logic [2:0] sweep_cnt; // env_ticks since last change
    logic       sweep_due;
    logic       at_limit;

    assign sweep_due = env_tick && (env_sweeps != 3'd0) &&
                       (sweep_cnt + 3'd1 == env_sweeps);

    // Saturate at full scale or silence
    assign at_limit  = env_increasing ? (volume == '1) : (volume == '0);

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            volume    <= '0;
            sweep_cnt <= '0;
        end else if (trigger) begin
            volume    <= initial_volume; // Restart from programmed level
            sweep_cnt <= '0;
        end else if (sweep_due) begin
            sweep_cnt <= '0;
            if (!at_limit) begin
                if (env_increasing)
                    volume <= volume + 1'b1;
                else
                    volume <= volume - 1'b1;
            end
        end else if (env_tick && env_sweeps != 3'd0) begin
            sweep_cnt <= sweep_cnt + 3'd1;
        end
        // Sweeps of 0: volume held
    end

endmodule

// File: src/length_counter.sv
`timescale 1ns/1ps

module length_counter (
    input  logic                        clk,
    input  logic                        start,
    input  logic                        trigger,
    input  logic                        length_tick,
    input  logic [noise_pkg::LEN_W-1:0] length,
    input  logic                        single,
    input  logic                        dac_on,
    output logic                        channel_on
);

    logic [noise_pkg::LEN_W:0] count; // Remaining ticks, up to 64

    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            count      <= '0;
            channel_on <= 1'b0;
        end else if (trigger) begin
            count      <= (1 << noise_pkg::LEN_W) - length; // 64 - length
            channel_on <= dac_on;
        end else if (!dac_on) begin
            channel_on <= 1'b0; // DAC power-down kills the voice
        end else if (length_tick && single && channel_on) begin
            count <= count - 1'b1;
            if (count == 1)
                channel_on <= 1'b0; // Expired
        end
    end

    a_on_needs_trigger: assert property (
        @(posedge clk) disable iff (start) $rose(channel_on) |-> $past(trigger)
    );

endmodule

// File: src/noise_output_stage.sv
`timescale 1ns/1ps

module noise_output_stage (
    input  logic                        clk,
    input  logic                        start,
    input  logic                        channel_on,
    input  logic                        noise_bit,
    input  logic [noise_pkg::VOL_W-1:0] volume,
    output logic [noise_pkg::VOL_W-1:0] level,
    output logic                        enable
);

    // Registered DAC level, one cycle behind its inputs
    always_ff @(posedge clk or posedge start) begin
        if (start) begin
            level  <= '0;
            enable <= 1'b0;
        end else begin
            level  <= (channel_on && noise_bit) ? volume : '0; // Gate by noise
            enable <= channel_on;
        end
    end

endmodule

// File: src/noise_channel_top.sv
`timescale 1ns/1ps

module noise_channel_top (
    input  logic                        clk,
    input  logic                        start,
    input  logic                        wr_en,
    input  logic [1:0]                  wr_addr,
    input  logic [7:0]                  wr_data,
    output logic [noise_pkg::VOL_W-1:0] level,
    output logic                        enable
);

    logic [noise_pkg::LEN_W-1:0] length;
    logic [noise_pkg::VOL_W-1:0] initial_volume;
    logic                        env_increasing;
    logic [2:0]                  env_sweeps;
    logic [3:0]                  shift_prescale;
    logic                        short_mode;
    logic [2:0]                  div_ratio;
    logic                        single;
    logic                        trigger;
    logic                        dac_on;
    logic                        length_tick;  // Frame strobes
    logic                        env_tick;
    logic                        noise_bit;
    logic [noise_pkg::VOL_W-1:0] volume;
    logic                        channel_on;

    ////////////////////
    // Decode
    ////////////////////

    noise_reg_decode u_decode (
        .clk(clk), .start(start), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .length(length), .initial_volume(initial_volume),
        .env_increasing(env_increasing), .env_sweeps(env_sweeps),
        .shift_prescale(shift_prescale), .short_mode(short_mode),
        .div_ratio(div_ratio), .single(single), .trigger(trigger), .dac_on(dac_on)
    );

    ////////////////////
    // Execute
    ////////////////////

    frame_sequencer u_frame (
        .clk(clk), .start(start), .length_tick(length_tick), .env_tick(env_tick)
    );

    noise_lfsr_gen u_lfsr (
        .clk(clk), .start(start), .trigger(trigger), .shift_prescale(shift_prescale),
        .short_mode(short_mode), .div_ratio(div_ratio), .noise_bit(noise_bit)
    );

    volume_envelope u_env (
        .clk(clk), .start(start), .trigger(trigger), .env_tick(env_tick),
        .initial_volume(initial_volume), .env_increasing(env_increasing),
        .env_sweeps(env_sweeps), .volume(volume)
    );

    length_counter u_length (
        .clk(clk), .start(start), .trigger(trigger), .length_tick(length_tick),
        .length(length), .single(single), .dac_on(dac_on), .channel_on(channel_on)
    );

    ////////////////////
    // Result
    ////////////////////

    noise_output_stage u_out (
        .clk(clk), .start(start), .channel_on(channel_on), .noise_bit(noise_bit),
        .volume(volume), .level(level), .enable(enable)
    );

endmodule

// File: verif/tb_noise_channel.sv
`timescale 1ns/1ps

module tb_noise_channel;

    localparam integer TIMEOUT_CYCLES = 60000; // About twice the summed test lengths
    localparam integer FRAME_CLKS     = noise_pkg::FRAME_STEP_CLKS;

    logic                        clk;
    logic                        start;
    logic                        wr_en;
    logic [1:0]                  wr_addr;
    logic [7:0]                  wr_data;
    logic [noise_pkg::VOL_W-1:0] level;
    logic                        enable;

    integer errors;
    integer cyc;      // Edges since reset release

    noise_channel_top dut (
        .clk(clk), .start(start), .wr_en(wr_en), .wr_addr(wr_addr),
        .wr_data(wr_data), .level(level), .enable(enable)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    // Frame position tracker and run limit
    always @(posedge clk) begin
        if (!start)
            cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Bus and timing helpers
    ////////////////////

    task automatic step_clk(input integer n);
        repeat (n) begin
            @(posedge clk);
            #1; // Stimulus and sampling point
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        step_clk(1);
        wr_en   = 1'b0;
    endtask

    // Idle until cyc hits phase ph within a span of cycles
    task automatic wait_phase(input integer span, input integer ph);
        while (cyc % span != ph)
            step_clk(1);
    endtask

    task automatic check_level(input string name, input logic [noise_pkg::VOL_W-1:0] exp_lvl,
                               input logic [noise_pkg::VOL_W-1:0] act_lvl);
        if (act_lvl !== exp_lvl) begin
            errors++;
            $display("ERROR %s: expected level %0d, got %0d", name, exp_lvl, act_lvl);
        end
    endtask

    task automatic check_enable(input string name, input logic exp_en, input logic act_en);
        if (act_en !== exp_en) begin
            errors++;
            $display("ERROR %s: expected enable %0b, got %0b", name, exp_en, act_en);
        end
    endtask

    // Reference noise register, one shift
    function automatic logic [14:0] lfsr_step(input logic [14:0] s, input logic short_w);
        logic fb;
        fb = s[0] ^ s[1];
        if (short_w)
            return {8'd0, fb, s[6:1]}; // 7-bit mode
        return {fb, s[14:1]};
    endfunction

    ////////////////////
    // Tests
    ////////////////////

    task automatic reset_dac_off();
        check_level("reset", 4'd0, level);
        check_enable("reset", 1'b0, enable);
        write_reg(noise_pkg::ADDR_ENVELOPE, 8'h00); // Silent and falling, DAC off
        write_reg(noise_pkg::ADDR_CONTROL, 8'h80);
        repeat (16) begin
            step_clk(1);
            check_enable("dac off", 1'b0, enable);
        end
    endtask

    // Trigger, then sample mid-period against the model
    task automatic run_lfsr(input string name, input logic short_w, input logic [2:0] ratio,
                            input logic [1:0] pre, input integer nsteps);
        logic [14:0] model;
        logic [3:0]  exp_lvl;
        logic [3:0]  expected[$]; // Model levels, one per step
        integer      div;
        integer      period;
        model  = '1;
        div    = (ratio == 3'd0) ? noise_pkg::NOISE_BASE_DIV
                                 : ratio * noise_pkg::NOISE_RATIO_MULT;
        period = div << pre;
        write_reg(noise_pkg::ADDR_ENVELOPE, 8'hF0); // Full volume, no sweep
        write_reg(noise_pkg::ADDR_POLY, {2'b00, pre, short_w, ratio});
        write_reg(noise_pkg::ADDR_CONTROL, 8'h80);
        step_clk(1 + period / 2); // Trigger edge, then middle of step 0
        for (int n = 0; n < nsteps; n++) begin
            exp_lvl = model[0] ? 4'd0 : 4'd15;
            check_level(name, exp_lvl, level);
            // 7-bit sequence comes round again after 127 steps
            if (short_w && n >= 127)
                check_level({name, " repeat"}, expected[n - 127], level);
            expected.push_back(exp_lvl);
            model = lfsr_step(model, short_w);
            step_clk(period);
        end
    endtask

    task automatic length_expiry();
        logic [5:0] len;
        integer     ticks;
        string      name;
        len   = 6'd40 + 6'($urandom % 24);
        ticks = 64 - len;
        write_reg(noise_pkg::ADDR_LENGTH, {2'b00, len});
        write_reg(noise_pkg::ADDR_ENVELOPE, 8'hF0);
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 0)
                name = "length single";
            else
                name = "length continuous";
            // Trigger lands just after a length tick (end of even step)
            wait_phase(2 * FRAME_CLKS, FRAME_CLKS + 4);
            write_reg(noise_pkg::ADDR_CONTROL, (pass == 0) ? 8'hC0 : 8'h80);
            step_clk(2 * FRAME_CLKS * ticks - FRAME_CLKS / 2);
            check_enable(name, 1'b1, enable); // Last tick still ahead
            step_clk(FRAME_CLKS + FRAME_CLKS / 2);
            check_enable(name, pass == 1, enable);
        end
    endtask

    // Peak level per envelope period, windows clear of the tick edge
    task automatic envelope_sweep();
        logic [3:0] peak;
        logic [3:0] exp_v;
        integer     nwin;
        write_reg(noise_pkg::ADDR_POLY, 8'h00); // Fastest noise
        for (int dir = 0; dir < 2; dir++) begin
            nwin = (dir == 0) ? 15 : 5;
            write_reg(noise_pkg::ADDR_ENVELOPE, (dir == 0) ? 8'h29 : 8'h31);
            wait_phase(8 * FRAME_CLKS, 8);
            write_reg(noise_pkg::ADDR_CONTROL, 8'h80);
            step_clk(5);
            for (int k = 0; k < nwin; k++) begin
                peak = 4'd0;
                repeat (8 * FRAME_CLKS - 32) begin
                    if (level > peak)
                        peak = level;
                    step_clk(1);
                end
                if (dir == 0)
                    exp_v = (2 + k > 15) ? 4'd15 : 4'(2 + k);
                else
                    exp_v = (k > 3) ? 4'd0 : 4'(3 - k);
                check_level(dir == 0 ? "envelope up" : "envelope down", exp_v, peak);
                check_enable("envelope", 1'b1, enable);
                step_clk(32);
            end
        end
    endtask

    initial begin
        logic [2:0] ratio;
        logic [1:0] pre;
        void'($urandom(32'h29d98bdd));
        errors   = 0;
        cyc      = 0;
        start    = 1'b1;
        wr_en    = 1'b0;
        wr_addr  = 2'd0;
        wr_data  = 8'd0;
        repeat (2) @(posedge clk);
        #1;
        start = 1'b0;

        reset_dac_off();
        ratio = 3'($urandom % 8);
        pre   = 2'($urandom % 4);
        run_lfsr("long lfsr", 1'b0, ratio, pre, 40);
        run_lfsr("short mode", 1'b1, 3'd0, 2'd0, 140);
        length_expiry();
        envelope_sweep();
        run_lfsr("retrigger first", 1'b0, 3'd1, 2'd0, 12);
        run_lfsr("retrigger second", 1'b0, 3'd1, 2'd0, 30); // Lands mid-sequence

        $display("Tests complete with %0d errors", errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: filelist.f
src/noise_pkg.sv
src/noise_reg_decode.sv
src/frame_sequencer.sv
src/noise_lfsr_gen.sv
src/volume_envelope.sv
src/length_counter.sv
src/noise_output_stage.sv
src/noise_channel_top.sv
verif/tb_noise_channel.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the noise channel testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_noise_channel -Mdir obj_dir -o sim_noise \
    && ./obj_dir/sim_noise > sim.log 2>&1 \
    || echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0
